//--- hdl/issue_consts.svh
// issue stage constants
`ifndef ISSUE_CONSTS_SVH
`define ISSUE_CONSTS_SVH

// ------------------------------------------------------------
// datapath widths
// ------------------------------------------------------------

// data word and pc width
`define ISSUE_XLEN 32

// integer register index width
`define ISSUE_REG_ADDR_W 5

// scoreboard transaction id width, eight entries in flight
`define ISSUE_TRANS_ID_W 3

// ------------------------------------------------------------
// counts
// ------------------------------------------------------------

// architectural integer registers, x0 included
`define ISSUE_NR_REGS 32

// write ports coming back from the commit stage
`define ISSUE_NR_COMMIT_PORTS 2

`endif

//--- hdl/issue_pkg.sv
// issue stage types
`include "issue_consts.svh"

package issue_pkg;

    // ------------------------------------------------------------
    // plain vectors
    // ------------------------------------------------------------
    typedef logic [`ISSUE_XLEN-1:0]       xlen_t;
    typedef logic [`ISSUE_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`ISSUE_TRANS_ID_W-1:0] trans_id_t;

    // ------------------------------------------------------------
    // encodings
    // ------------------------------------------------------------
    // functional unit an instruction needs, NONE for no unit at all
    typedef enum logic [2:0] {NONE, ALU, CTRL_FLOW, MULT, LOAD, STORE, CSR} fu_t;

    // reduced operation set
    typedef enum logic [3:0] {ADD, SUB, AND, OR, MUL, LW, SW, BEQ, CSRRW} fu_op_t;

    // pending writer per register, NONE when nothing is in flight
    typedef fu_t [`ISSUE_NR_REGS-1:0] clobber_vec_t;

    // ------------------------------------------------------------
    // structs
    // ------------------------------------------------------------
    // decoded instruction at the scoreboard head
    typedef struct packed {
        fu_t       fu;
        fu_op_t    op;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        // immediate
        xlen_t     result;
        xlen_t     pc;
        trans_id_t trans_id;
        logic      use_imm;
        logic      use_pc;
        logic      use_zimm;
        // exception already raised upstream
        logic      ex_valid;
    } issue_instr_t;

    // one register file write from commit
    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        xlen_t     wdata;
    } commit_port_t;

    // operands handed to the functional units
    typedef struct packed {
        fu_t       fu;
        fu_op_t    op;
        xlen_t     operand_a;
        xlen_t     operand_b;
        xlen_t     imm;
        trans_id_t trans_id;
    } fu_data_t;

endpackage

//--- hdl/int_regfile.sv
// integer register file
`timescale 1ns/1ps
`include "issue_consts.svh"

module int_regfile #(
    parameter int unsigned NR_WRITE_PORTS = `ISSUE_NR_COMMIT_PORTS
) (
    input  logic                                     clk_i,
    input  logic                                     rst_uarch_ni,
    // read ports, one per source operand
    input  issue_pkg::reg_addr_t                     raddr_a_i,
    input  issue_pkg::reg_addr_t                     raddr_b_i,
    output issue_pkg::xlen_t                         rdata_a_o,
    output issue_pkg::xlen_t                         rdata_b_o,
    // write ports from commit
    input  issue_pkg::commit_port_t [NR_WRITE_PORTS-1:0] commit_i
);
    import issue_pkg::*;

    // x0 has no storage
    xlen_t regs_q [1:`ISSUE_NR_REGS-1];

    // ------------------------------------------------------------
    // write side
    // ------------------------------------------------------------
    // ports are scanned in order so the highest port index lands last
    always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
        if (!rst_uarch_ni) begin
            for (int r = 1; r < `ISSUE_NR_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            for (int p = 0; p < NR_WRITE_PORTS; p++) begin
                // writes to x0 are dropped
                if (commit_i[p].we && (commit_i[p].waddr != '0)) begin
                    regs_q[commit_i[p].waddr] <= commit_i[p].wdata;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // read side
    // ------------------------------------------------------------
    // combinational, a same-cycle write is not visible yet
    always_comb begin
        rdata_a_o = '0;
        rdata_b_o = '0;
        if (raddr_a_i != '0) begin
            rdata_a_o = regs_q[raddr_a_i];
        end
        if (raddr_b_i != '0) begin
            rdata_b_o = regs_q[raddr_b_i];
        end
    end

endmodule

//--- hdl/hazard_check.sv
// source operand hazard check
`timescale 1ns/1ps

module hazard_check (
    input  issue_pkg::issue_instr_t instr_i,
    // pending writer per register
    input  issue_pkg::clobber_vec_t clobber_i,
    // scoreboard has the producer result ready
    input  logic                    rs1_valid_i,
    input  logic                    rs2_valid_i,
    // take the scoreboard value instead of the register file
    output logic                    fwd_rs1_o,
    output logic                    fwd_rs2_o,
    // some source is not available yet
    output logic                    stall_o
);
    import issue_pkg::*;

    fu_t  rs1_writer;
    fu_t  rs2_writer;
    logic rs1_pending;
    logic rs2_pending;
    logic rs1_ready;
    logic rs2_ready;

    // ------------------------------------------------------------
    // clobber lookup
    // ------------------------------------------------------------
    assign rs1_writer = clobber_i[instr_i.rs1];
    assign rs2_writer = clobber_i[instr_i.rs2];

    // zimm carries the rs1 field as an immediate, nothing to wait for
    assign rs1_pending = !instr_i.use_zimm && (rs1_writer != NONE);
    assign rs2_pending = (rs2_writer != NONE);

    // csr results only reach us through the register file
    assign rs1_ready = rs1_valid_i && (rs1_writer != CSR);
    assign rs2_ready = rs2_valid_i && (rs2_writer != CSR);

    // ------------------------------------------------------------
    // forward or stall
    // ------------------------------------------------------------
    always_comb begin
        fwd_rs1_o = 1'b0;
        fwd_rs2_o = 1'b0;
        stall_o   = 1'b0;

        if (rs1_pending) begin
            if (rs1_ready) begin
                fwd_rs1_o = 1'b1;
            end else begin
                stall_o = 1'b1;
            end
        end

        if (rs2_pending) begin
            if (rs2_ready) begin
                fwd_rs2_o = 1'b1;
            end else begin
                stall_o = 1'b1;
            end
        end
    end

endmodule

//--- hdl/operand_select.sv
// operand select and id/ex register
`timescale 1ns/1ps
`include "issue_consts.svh"

module operand_select (
    input  logic                    clk_i,
    input  logic                    rst_uarch_ni,
    input  issue_pkg::issue_instr_t instr_i,
    // register file read data
    input  issue_pkg::xlen_t        rf_a_i,
    input  issue_pkg::xlen_t        rf_b_i,
    // scoreboard forwarded values
    input  issue_pkg::xlen_t        fwd_a_i,
    input  issue_pkg::xlen_t        fwd_b_i,
    input  logic                    fwd_rs1_i,
    input  logic                    fwd_rs2_i,
    // towards the functional units
    output issue_pkg::fu_data_t     fu_data_o,
    output issue_pkg::xlen_t        pc_o
);
    import issue_pkg::*;

    xlen_t    operand_a_n;
    xlen_t    operand_b_n;
    fu_data_t fu_data_n;

    // ------------------------------------------------------------
    // operand a
    // ------------------------------------------------------------
    // priority from low to high: regfile, forward, pc, zimm
    always_comb begin
        operand_a_n = rf_a_i;
        if (fwd_rs1_i) begin
            operand_a_n = fwd_a_i;
        end
        if (instr_i.use_pc) begin
            operand_a_n = instr_i.pc;
        end
        // zero extended rs1 index
        if (instr_i.use_zimm) begin
            operand_a_n = {{(`ISSUE_XLEN-`ISSUE_REG_ADDR_W){1'b0}}, instr_i.rs1};
        end
    end

    // ------------------------------------------------------------
    // operand b
    // ------------------------------------------------------------
    always_comb begin
        operand_b_n = rf_b_i;
        if (fwd_rs2_i) begin
            operand_b_n = fwd_b_i;
        end
        // stores and branches keep rs2 here, their immediate goes through imm
        if (instr_i.use_imm && (instr_i.fu != STORE) && (instr_i.fu != CTRL_FLOW)) begin
            operand_b_n = instr_i.result;
        end
    end

    // next id/ex contents
    always_comb begin
        fu_data_n.fu        = instr_i.fu;
        fu_data_n.op        = instr_i.op;
        fu_data_n.operand_a = operand_a_n;
        fu_data_n.operand_b = operand_b_n;
        fu_data_n.imm       = instr_i.result;
        fu_data_n.trans_id  = instr_i.trans_id;
    end

    // ------------------------------------------------------------
    // id/ex register
    // ------------------------------------------------------------
    // loaded every cycle, the valid lines say when it matters
    always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
        if (!rst_uarch_ni) begin
            fu_data_o <= '{fu: NONE, op: ADD, default: '0};
            pc_o      <= '0;
        end else begin
            fu_data_o <= fu_data_n;
            pc_o      <= instr_i.pc;
        end
    end

endmodule

//--- hdl/issue_ctrl.sv
// issue acknowledge and unit valids
`timescale 1ns/1ps
`include "issue_consts.svh"

module issue_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_uarch_ni,
    input  logic                    flush_i,
    // scoreboard head
    input  issue_pkg::issue_instr_t instr_i,
    input  logic                    instr_valid_i,
    // from hazard_check
    input  logic                    stall_i,
    input  issue_pkg::clobber_vec_t clobber_i,
    input  issue_pkg::commit_port_t [`ISSUE_NR_COMMIT_PORTS-1:0] commit_i,
    // unit readiness
    input  logic                    flu_ready_i,
    input  logic                    lsu_ready_i,
    output logic                    issue_ack_o,
    // one-hot unit valids, one cycle after accept
    output logic                    alu_valid_o,
    output logic                    branch_valid_o,
    output logic                    mult_valid_o,
    output logic                    lsu_valid_o,
    output logic                    csr_valid_o
);
    import issue_pkg::*;

    logic fu_busy;
    logic rd_free;
    logic rd_committing;
    logic accept;
    logic alu_valid_q;
    logic branch_valid_q;
    logic mult_valid_q;
    logic lsu_valid_q;
    logic csr_valid_q;

    // ------------------------------------------------------------
    // unit busy
    // ------------------------------------------------------------
    // fixed latency units share one ready
    always_comb begin
        unique case (instr_i.fu)
            ALU, CTRL_FLOW, MULT, CSR: fu_busy = !flu_ready_i;
            LOAD, STORE:               fu_busy = !lsu_ready_i;
            default:                   fu_busy = 1'b0;
        endcase
    end

    // ------------------------------------------------------------
    // waw check
    // ------------------------------------------------------------
    assign rd_free = (clobber_i[instr_i.rd] == NONE);

    // a commit retiring rd this cycle clears the pending writer
    always_comb begin
        rd_committing = 1'b0;
        for (int p = 0; p < `ISSUE_NR_COMMIT_PORTS; p++) begin
            if (commit_i[p].we && (commit_i[p].waddr == instr_i.rd)) begin
                rd_committing = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // acknowledge
    // ------------------------------------------------------------
    always_comb begin
        issue_ack_o = 1'b0;
        if (instr_valid_i) begin
            if (!stall_i && !fu_busy && (rd_free || rd_committing)) begin
                issue_ack_o = 1'b1;
            end
            // exceptions and unit-less instructions just retire through
            if (instr_i.ex_valid || (instr_i.fu == NONE)) begin
                issue_ack_o = 1'b1;
            end
        end
        // back to back only for multiplies, the result bus is shared
        if (mult_valid_q && (instr_i.fu != MULT)) begin
            issue_ack_o = 1'b0;
        end
    end

    assign accept = instr_valid_i && issue_ack_o && !instr_i.ex_valid;

    // ------------------------------------------------------------
    // unit valid registers
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
        if (!rst_uarch_ni) begin
            alu_valid_q    <= 1'b0;
            branch_valid_q <= 1'b0;
            mult_valid_q   <= 1'b0;
            lsu_valid_q    <= 1'b0;
            csr_valid_q    <= 1'b0;
        end else begin
            // single cycle pulses
            alu_valid_q    <= 1'b0;
            branch_valid_q <= 1'b0;
            mult_valid_q   <= 1'b0;
            lsu_valid_q    <= 1'b0;
            csr_valid_q    <= 1'b0;
            // flush wins over a same-edge accept
            if (accept && !flush_i) begin
                case (instr_i.fu)
                    ALU:         alu_valid_q    <= 1'b1;
                    CTRL_FLOW:   branch_valid_q <= 1'b1;
                    MULT:        mult_valid_q   <= 1'b1;
                    LOAD, STORE: lsu_valid_q    <= 1'b1;
                    CSR:         csr_valid_q    <= 1'b1;
                    default:     ;
                endcase
            end
        end
    end

    assign alu_valid_o    = alu_valid_q;
    assign branch_valid_o = branch_valid_q;
    assign mult_valid_o   = mult_valid_q;
    assign lsu_valid_o    = lsu_valid_q;
    assign csr_valid_o    = csr_valid_q;

endmodule

//--- hdl/issue_read_operands.sv
// issue and operand read stage
`timescale 1ns/1ps
`include "issue_consts.svh"

module issue_read_operands (
    input  logic                    clk_i,
    input  logic                    rst_uarch_ni,
    input  logic                    flush_i,
    // scoreboard head handshake
    input  issue_pkg::issue_instr_t issue_instr_i,
    input  logic                    issue_instr_valid_i,
    output logic                    issue_ack_o,
    // scoreboard operand lookup
    output issue_pkg::reg_addr_t    rs1_o,
    input  issue_pkg::xlen_t        rs1_i,
    input  logic                    rs1_valid_i,
    output issue_pkg::reg_addr_t    rs2_o,
    input  issue_pkg::xlen_t        rs2_i,
    input  logic                    rs2_valid_i,
    input  issue_pkg::clobber_vec_t clobber_i,
    // commit write back
    input  issue_pkg::commit_port_t [`ISSUE_NR_COMMIT_PORTS-1:0] commit_i,
    // functional units
    input  logic                    flu_ready_i,
    input  logic                    lsu_ready_i,
    output issue_pkg::fu_data_t     fu_data_o,
    output issue_pkg::xlen_t        pc_o,
    output logic                    alu_valid_o,
    output logic                    branch_valid_o,
    output logic                    mult_valid_o,
    output logic                    lsu_valid_o,
    output logic                    csr_valid_o
);
    import issue_pkg::*;

    logic  fwd_rs1;
    logic  fwd_rs2;
    logic  stall;
    xlen_t rf_rdata_a;
    xlen_t rf_rdata_b;

    // scoreboard is polled with the raw source indices
    assign rs1_o = issue_instr_i.rs1;
    assign rs2_o = issue_instr_i.rs2;

    // ------------------------------------------------------------
    // operand availability
    // ------------------------------------------------------------
    hazard_check hazard_check_inst (
        .instr_i     (issue_instr_i),
        .clobber_i   (clobber_i),
        .rs1_valid_i (rs1_valid_i),
        .rs2_valid_i (rs2_valid_i),
        .fwd_rs1_o   (fwd_rs1),
        .fwd_rs2_o   (fwd_rs2),
        .stall_o     (stall)
    );

    int_regfile #(
        .NR_WRITE_PORTS (`ISSUE_NR_COMMIT_PORTS)
    ) int_regfile_inst (
        .clk_i        (clk_i),
        .rst_uarch_ni (rst_uarch_ni),
        .raddr_a_i    (issue_instr_i.rs1),
        .raddr_b_i    (issue_instr_i.rs2),
        .rdata_a_o    (rf_rdata_a),
        .rdata_b_o    (rf_rdata_b),
        .commit_i     (commit_i)
    );

    // ------------------------------------------------------------
    // datapath and control
    // ------------------------------------------------------------
    operand_select operand_select_inst (
        .clk_i        (clk_i),
        .rst_uarch_ni (rst_uarch_ni),
        .instr_i      (issue_instr_i),
        .rf_a_i       (rf_rdata_a),
        .rf_b_i       (rf_rdata_b),
        .fwd_a_i      (rs1_i),
        .fwd_b_i      (rs2_i),
        .fwd_rs1_i    (fwd_rs1),
        .fwd_rs2_i    (fwd_rs2),
        .fu_data_o    (fu_data_o),
        .pc_o         (pc_o)
    );

    issue_ctrl issue_ctrl_inst (
        .clk_i          (clk_i),
        .rst_uarch_ni   (rst_uarch_ni),
        .flush_i        (flush_i),
        .instr_i        (issue_instr_i),
        .instr_valid_i  (issue_instr_valid_i),
        .stall_i        (stall),
        .clobber_i      (clobber_i),
        .commit_i       (commit_i),
        .flu_ready_i    (flu_ready_i),
        .lsu_ready_i    (lsu_ready_i),
        .issue_ack_o    (issue_ack_o),
        .alu_valid_o    (alu_valid_o),
        .branch_valid_o (branch_valid_o),
        .mult_valid_o   (mult_valid_o),
        .lsu_valid_o    (lsu_valid_o),
        .csr_valid_o    (csr_valid_o)
    );

endmodule

//--- bench/tb_issue_read_operands.sv
// issue stage testbench
`timescale 1ns/1ps
`include "issue_consts.svh"

module tb_issue_read_operands;
    import issue_pkg::*;

    // one-hot order {alu, branch, mult, lsu, csr}
    localparam logic [4:0] V_NONE = 5'b00000;
    localparam logic [4:0] V_ALU  = 5'b10000;
    localparam logic [4:0] V_BR   = 5'b01000;
    localparam logic [4:0] V_MUL  = 5'b00100;
    localparam logic [4:0] V_LSU  = 5'b00010;
    localparam logic [4:0] V_CSR  = 5'b00001;
    // summed cycle budget of the six tests
    localparam int TEST_CYCLES = 10 + 25 + 20 + 20 + 20 + 10;

    logic         clk_i = 1'b0;
    logic         rst_uarch_ni;
    logic         flush_i;
    issue_instr_t issue_instr_i;
    logic         issue_instr_valid_i;
    xlen_t        rs1_i;
    xlen_t        rs2_i;
    logic         rs1_valid_i;
    logic         rs2_valid_i;
    clobber_vec_t clobber_i;
    commit_port_t [`ISSUE_NR_COMMIT_PORTS-1:0] commit_i;
    logic         flu_ready_i;
    logic         lsu_ready_i;
    logic         issue_ack_o;
    reg_addr_t    rs1_o;
    reg_addr_t    rs2_o;
    fu_data_t     fu_data_o;
    xlen_t        pc_o;
    logic         alu_valid_o;
    logic         branch_valid_o;
    logic         mult_valid_o;
    logic         lsu_valid_o;
    logic         csr_valid_o;

    // register file model, written alongside every commit
    xlen_t        model_regs [0:`ISSUE_NR_REGS-1];
    integer       seed;
    int           checks_passed;
    int           checks_failed;
    int           test_num;
    int           fails_at_start;
    xlen_t        val_a;
    issue_instr_t ins;

    issue_read_operands issue_read_operands_inst (
        .clk_i               (clk_i),
        .rst_uarch_ni        (rst_uarch_ni),
        .flush_i             (flush_i),
        .issue_instr_i       (issue_instr_i),
        .issue_instr_valid_i (issue_instr_valid_i),
        .issue_ack_o         (issue_ack_o),
        .rs1_o               (rs1_o),
        .rs1_i               (rs1_i),
        .rs1_valid_i         (rs1_valid_i),
        .rs2_o               (rs2_o),
        .rs2_i               (rs2_i),
        .rs2_valid_i         (rs2_valid_i),
        .clobber_i           (clobber_i),
        .commit_i            (commit_i),
        .flu_ready_i         (flu_ready_i),
        .lsu_ready_i         (lsu_ready_i),
        .fu_data_o           (fu_data_o),
        .pc_o                (pc_o),
        .alu_valid_o         (alu_valid_o),
        .branch_valid_o      (branch_valid_o),
        .mult_valid_o        (mult_valid_o),
        .lsu_valid_o         (lsu_valid_o),
        .csr_valid_o         (csr_valid_o)
    );

    always #20 clk_i = ~clk_i;

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) begin
            checks_passed++;
        end else begin
            checks_failed++;
            $display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // instruction with every flag clear, pc derived from rd
    function automatic issue_instr_t make_instr(input fu_t fu, input fu_op_t op,
                                                input reg_addr_t rs1, input reg_addr_t rs2,
                                                input reg_addr_t rd, input xlen_t imm);
        issue_instr_t i;
        i          = '0;
        i.fu       = fu;
        i.op       = op;
        i.rs1      = rs1;
        i.rs2      = rs2;
        i.rd       = rd;
        i.result   = imm;
        i.pc       = 32'h8000_0000 | {rd, 2'b00};
        i.trans_id = rd[2:0];
        return i;
    endfunction

    task automatic clear_clobber();
        for (int r = 0; r < `ISSUE_NR_REGS; r++) begin
            clobber_i[r] = NONE;
        end
    endtask

    task automatic set_commit(input int port, input reg_addr_t addr, input xlen_t data);
        commit_i[port].we    = 1'b1;
        commit_i[port].waddr = addr;
        commit_i[port].wdata = data;
    endtask

    // drop the write enables and bring the model up to date
    task automatic retire_commits();
        for (int p = 0; p < `ISSUE_NR_COMMIT_PORTS; p++) begin
            if (commit_i[p].we && (commit_i[p].waddr != '0)) begin
                model_regs[commit_i[p].waddr] = commit_i[p].wdata;
            end
            commit_i[p].we = 1'b0;
        end
    endtask

    // called at a falling edge, returns at the next one with valid dropped
    task automatic issue_and_check(input issue_instr_t i, input logic exp_ack,
                                   input logic [4:0] exp_valids);
        issue_instr_i       = i;
        issue_instr_valid_i = 1'b1;
        // ack settles well before the rising edge
        #5;
        check_value("issue ack", issue_ack_o, exp_ack);
        check_value("rs1 index", rs1_o, i.rs1);
        check_value("rs2 index", rs2_o, i.rs2);
        @(posedge clk_i);
        @(negedge clk_i);
        issue_instr_valid_i = 1'b0;
        check_value("unit valids",
                    {alu_valid_o, branch_valid_o, mult_valid_o, lsu_valid_o, csr_valid_o},
                    exp_valids);
        // id/ex register takes the head instruction at every edge
        check_value("id/ex fu", fu_data_o.fu, i.fu);
        check_value("id/ex op", fu_data_o.op, i.op);
        check_value("id/ex trans id", fu_data_o.trans_id, i.trans_id);
        check_value("id/ex pc", pc_o, i.pc);
    endtask

    task automatic begin_test();
        test_num++;
        fails_at_start = checks_failed;
    endtask

    task automatic end_test(input string name);
        if (checks_failed == fails_at_start) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, checks_failed - fails_at_start);
        end
    endtask

    // ------------------------------------------------------------
    // watchdog
    // ------------------------------------------------------------
    initial begin
        #(2 * TEST_CYCLES * 40);
        $display("timeout: the tests did not finish within %0d ns", 2 * TEST_CYCLES * 40);
        $display(">>> FAIL");
        $finish;
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    initial begin
        seed                = 81;
        checks_passed       = 0;
        checks_failed       = 0;
        test_num            = 0;
        rst_uarch_ni        = 1'b0;
        flush_i             = 1'b0;
        issue_instr_i       = '0;
        issue_instr_valid_i = 1'b0;
        rs1_i               = '0;
        rs2_i               = '0;
        rs1_valid_i         = 1'b0;
        rs2_valid_i         = 1'b0;
        commit_i            = '0;
        flu_ready_i         = 1'b1;
        lsu_ready_i         = 1'b1;
        clear_clobber();
        for (int r = 0; r < `ISSUE_NR_REGS; r++) begin
            model_regs[r] = '0;
        end

        // reset and idle
        begin_test();
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_uarch_ni = 1'b1;
        repeat (3) begin
            check_value("idle ack", issue_ack_o, 1'b0);
            check_value("idle valids",
                        {alu_valid_o, branch_valid_o, mult_valid_o, lsu_valid_o, csr_valid_o},
                        V_NONE);
            check_value("reset fu", fu_data_o.fu, NONE);
            @(negedge clk_i);
        end
        end_test("reset and idle");

        // register read and immediate
        begin_test();
        set_commit(0, 5'd5, $random(seed));
        set_commit(1, 5'd6, $random(seed));
        @(negedge clk_i);
        retire_commits();
        // both ports on r9, port 1 has priority
        set_commit(0, 5'd9, $random(seed));
        set_commit(1, 5'd9, $random(seed));
        @(negedge clk_i);
        retire_commits();
        val_a = $random(seed);
        ins = make_instr(ALU, ADD, 5'd5, 5'd6, 5'd7, val_a);
        ins.use_imm = 1'b1;
        issue_and_check(ins, 1'b1, V_ALU);
        check_value("rf operand a", fu_data_o.operand_a, model_regs[5]);
        check_value("imm operand b", fu_data_o.operand_b, val_a);
        check_value("imm field", fu_data_o.imm, val_a);
        ins = make_instr(ALU, OR, 5'd9, 5'd6, 5'd7, '0);
        issue_and_check(ins, 1'b1, V_ALU);
        check_value("port priority", fu_data_o.operand_a, model_regs[9]);
        check_value("rf operand b", fu_data_o.operand_b, model_regs[6]);
        ins = make_instr(ALU, ADD, 5'd5, 5'd6, 5'd7, '0);
        ins.use_pc = 1'b1;
        ins.pc     = $random(seed);
        issue_and_check(ins, 1'b1, V_ALU);
        check_value("pc operand a", fu_data_o.operand_a, ins.pc);
        check_value("pc out", pc_o, ins.pc);
        // zimm ignores a pending writer on the rs1 field
        clobber_i[21] = ALU;
        ins = make_instr(CSR, CSRRW, 5'd21, 5'd0, 5'd8, '0);
        ins.use_zimm = 1'b1;
        issue_and_check(ins, 1'b1, V_CSR);
        check_value("zimm operand a", fu_data_o.operand_a, 32'd21);
        clear_clobber();
        ins = make_instr(ALU, ADD, 5'd0, 5'd5, 5'd7, '0);
        issue_and_check(ins, 1'b1, V_ALU);
        check_value("x0 operand a", fu_data_o.operand_a, 32'd0);
        // branches and stores keep rs2 in operand b even with use_imm
        val_a = $random(seed);
        ins = make_instr(CTRL_FLOW, BEQ, 5'd5, 5'd6, 5'd0, val_a);
        ins.use_imm = 1'b1;
        issue_and_check(ins, 1'b1, V_BR);
        check_value("branch operand b", fu_data_o.operand_b, model_regs[6]);
        check_value("branch imm", fu_data_o.imm, val_a);
        ins = make_instr(STORE, SW, 5'd5, 5'd9, 5'd0, val_a);
        ins.use_imm = 1'b1;
        issue_and_check(ins, 1'b1, V_LSU);
        check_value("store operand b", fu_data_o.operand_b, model_regs[9]);
        end_test("register read and immediate");

        // forwarding and stall
        begin_test();
        clobber_i[10] = ALU;
        rs1_i         = $random(seed);
        rs1_valid_i   = 1'b1;
        ins = make_instr(ALU, ADD, 5'd10, 5'd6, 5'd11, '0);
        issue_and_check(ins, 1'b1, V_ALU);
        check_value("forwarded a", fu_data_o.operand_a, rs1_i);
        check_value("rf b beside forward", fu_data_o.operand_b, model_regs[6]);
        clobber_i[12] = LOAD;
        rs2_i         = $random(seed);
        rs2_valid_i   = 1'b1;
        ins = make_instr(ALU, SUB, 5'd5, 5'd12, 5'd11, '0);
        issue_and_check(ins, 1'b1, V_ALU);
        check_value("forwarded b", fu_data_o.operand_b, rs2_i);
        rs1_valid_i = 1'b0;
        ins = make_instr(ALU, ADD, 5'd10, 5'd6, 5'd11, '0);
        issue_and_check(ins, 1'b0, V_NONE);
        // csr results are never forwarded
        clobber_i[10] = CSR;
        rs1_valid_i   = 1'b1;
        issue_and_check(ins, 1'b0, V_NONE);
        clear_clobber();
        rs1_valid_i = 1'b0;
        rs2_valid_i = 1'b0;
        end_test("forwarding and stall");

        // waw, commit bypass and busy
        begin_test();
        clobber_i[13] = MULT;
        ins = make_instr(ALU, ADD, 5'd5, 5'd6, 5'd13, '0);
        issue_and_check(ins, 1'b0, V_NONE);
        set_commit(1, 5'd13, $random(seed));
        issue_and_check(ins, 1'b1, V_ALU);
        retire_commits();
        clear_clobber();
        lsu_ready_i = 1'b0;
        ins = make_instr(LOAD, LW, 5'd5, 5'd0, 5'd14, 32'h10);
        issue_and_check(ins, 1'b0, V_NONE);
        ins = make_instr(ALU, AND, 5'd5, 5'd13, 5'd14, '0);
        issue_and_check(ins, 1'b1, V_ALU);
        check_value("committed rd read back", fu_data_o.operand_b, model_regs[13]);
        lsu_ready_i = 1'b1;
        ins = make_instr(LOAD, LW, 5'd5, 5'd0, 5'd14, 32'h10);
        issue_and_check(ins, 1'b1, V_LSU);
        flu_ready_i = 1'b0;
        ins = make_instr(ALU, ADD, 5'd5, 5'd6, 5'd15, '0);
        issue_and_check(ins, 1'b0, V_NONE);
        flu_ready_i = 1'b1;
        end_test("waw, commit bypass and busy");

        // exception, no unit and multiply exclusivity
        begin_test();
        clobber_i[10] = CSR;
        ins = make_instr(ALU, ADD, 5'd10, 5'd6, 5'd16, '0);
        ins.ex_valid = 1'b1;
        issue_and_check(ins, 1'b1, V_NONE);
        clear_clobber();
        ins = make_instr(NONE, ADD, 5'd5, 5'd6, 5'd16, '0);
        issue_and_check(ins, 1'b1, V_NONE);
        ins = make_instr(MULT, MUL, 5'd5, 5'd6, 5'd17, '0);
        issue_and_check(ins, 1'b1, V_MUL);
        // second multiply issues back to back
        issue_and_check(ins, 1'b1, V_MUL);
        ins = make_instr(ALU, ADD, 5'd5, 5'd6, 5'd18, '0);
        issue_and_check(ins, 1'b0, V_NONE);
        issue_and_check(ins, 1'b1, V_ALU);
        end_test("exception, no unit and multiply exclusivity");

        // flush
        begin_test();
        flush_i = 1'b1;
        ins = make_instr(ALU, ADD, 5'd5, 5'd6, 5'd19, '0);
        issue_and_check(ins, 1'b1, V_NONE);
        flush_i = 1'b0;
        issue_and_check(ins, 1'b1, V_ALU);
        end_test("flush");

        $display("checks: %0d passed, %0d failed", checks_passed, checks_failed);
        if (checks_failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+hdl
hdl/issue_pkg.sv
hdl/int_regfile.sv
hdl/hazard_check.sv
hdl/operand_select.sv
hdl/issue_ctrl.sv
hdl/issue_read_operands.sv
bench/tb_issue_read_operands.sv
